/* verilog.f */
+incdir+verilog
verilog/subBusPkg.sv
verilog/addressDecoder.sv
verilog/videoLatches.sv
verilog/frameWatchdog.sv
verilog/subBusTop.sv
verification/tbClock.sv
verification/subBusTb.sv

/* Makefile */
TOP := subBusTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* verification/subBusTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "subBusCfg.svh"

module subBusTb;

	logic nVBLK, rstN, busValid, busWrite, frameTick;
	logic [`SUB_ADDR_W-1:0] addr;
	logic [`SUB_DATA_W-1:0] data;
	logic nScr0, nScr1, nObj, nSnd, nSpgm, nMpgm, nBufEn, nRes, nIrq, tileBank;
	logic [`SCROLL_W-1:0] scrollX0, scrollX1, scrollX2, scrollX3;
	logic [`PRIO_W-1:0] prio0, prio1, prio2, prio3;
	logic [`SUB_DATA_W-1:0] romBank0, romBank1, backColor;

	// Reference model of the latch and frame state
	logic [`SCROLL_W-1:0] expScroll [4];
	logic [`PRIO_W-1:0] expPrio [4];
	logic [`SUB_DATA_W-1:0] expRom [2];
	logic [`SUB_DATA_W-1:0] expBack;
	logic expTile;
	logic expIrq;
	int expCnt;
	integer seed;

	tbClock tbClock_i (.nVBLK(nVBLK), .rstN(rstN));

	subBusTop subBusTop_i (
		.nVBLK(nVBLK), .rstN(rstN), .busValid(busValid), .busWrite(busWrite),
		.addr(addr), .data(data), .frameTick(frameTick),
		.nScr0(nScr0), .nScr1(nScr1), .nObj(nObj), .nSnd(nSnd),
		.nSpgm(nSpgm), .nMpgm(nMpgm), .nBufEn(nBufEn),
		.scrollX0(scrollX0), .scrollX1(scrollX1), .scrollX2(scrollX2), .scrollX3(scrollX3),
		.prio0(prio0), .prio1(prio1), .prio2(prio2), .prio3(prio3),
		.romBank0(romBank0), .romBank1(romBank1),
		.backColor(backColor), .tileBank(tileBank), .nRes(nRes), .nIrq(nIrq)
	);

	////////////////////////////////////////////////////////////////////////////
	// Checking and bus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, why);
	endtask

	task automatic checkValue(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("ERR %0t %s actual %0h expected %0h", $time, name, act, exp);
			failRun("output mismatch");
		end
	endtask

	// One bus cycle or tick presented for one clock
	task automatic drive(input logic v, input logic w, input logic [15:0] a,
			input logic [7:0] d, input logic t);
		@(posedge nVBLK);
		busValid <= v;
		busWrite <= w;
		addr <= a;
		data <= d;
		frameTick <= t;
	endtask

	// Idle for n edges and sample mid cycle
	task automatic idleThenSample(input int n);
		repeat (n) drive(1'b0, 1'b0, 16'h0000, 8'h00, 1'b0);
		@(negedge nVBLK);
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (!rstN && cycles < 20) begin
			@(posedge nVBLK);
			cycles++;
		end
		if (!rstN)
			failRun("reset was never released");
	endtask

	// Selects from the region table in the order nScr0 nScr1 nObj nSnd nSpgm nMpgm nBufEn
	function automatic logic [6:0] expectedSelects(input logic v, input logic w,
			input logic [15:0] a);
		logic scr0, scr1, snd, obj, spgm, mpgm, lth;
		scr0 = (a[15:13] == 3'b000);
		scr1 = (a[15:13] == 3'b001);
		// Sound owns 4000h to 43FFh and objects the rest of the 8K block
		snd = (a[15:10] == 6'b010000);
		obj = (a[15:13] == 3'b010) && !snd;
		spgm = (a[15:13] == 3'b011) && !w;
		mpgm = a[15] && !w;
		// Both scroll latch groups sit at 9000h to 97FFh
		lth = (a[15:11] == 5'b10010);
		if (!v)
			return 7'h7f;
		return ~{scr0, scr1, obj, snd, spgm, mpgm, scr0 | scr1 | obj | snd | lth};
	endfunction

	task automatic selectCycle(input logic v, input logic w, input logic [15:0] a,
			input logic [7:0] d);
		drive(v, w, a, d, 1'b0);
		idleThenSample(1);
		checkValue("{nScr0,nScr1,nObj,nSnd,nSpgm,nMpgm,nBufEn}",
			32'({nScr0, nScr1, nObj, nSnd, nSpgm, nMpgm, nBufEn}), 32'(expectedSelects(v, w, a)));
	endtask

	task automatic checkLatches();
		checkValue("scrollX0", 32'(scrollX0), 32'(expScroll[0]));
		checkValue("scrollX1", 32'(scrollX1), 32'(expScroll[1]));
		checkValue("scrollX2", 32'(scrollX2), 32'(expScroll[2]));
		checkValue("scrollX3", 32'(scrollX3), 32'(expScroll[3]));
		checkValue("prio0", 32'(prio0), 32'(expPrio[0]));
		checkValue("prio1", 32'(prio1), 32'(expPrio[1]));
		checkValue("prio2", 32'(prio2), 32'(expPrio[2]));
		checkValue("prio3", 32'(prio3), 32'(expPrio[3]));
		checkValue("romBank0", 32'(romBank0), 32'(expRom[0]));
		checkValue("romBank1", 32'(romBank1), 32'(expRom[1]));
		checkValue("backColor", 32'(backColor), 32'(expBack));
		checkValue("tileBank", 32'(tileBank), 32'(expTile));
	endtask

	task automatic checkFrame();
		checkValue("nRes", 32'(nRes), 32'(expCnt < `WDOG_RESET_AT));
		checkValue("nIrq", 32'(nIrq), 32'(expIrq));
	endtask

	// Counter and interrupt move one cycle after the tick
	task automatic tickFrame();
		drive(1'b0, 1'b0, 16'h0000, 8'h00, 1'b1);
		idleThenSample(1);
		expCnt = (expCnt == `WDOG_WRAP) ? 0 : expCnt + 1;
		expIrq = 1'b0;
		checkFrame();
	endtask

	task automatic clearWatchdog();
		drive(1'b1, 1'b1, `BASE_WDOG, 8'h00, 1'b0);
		idleThenSample(2);
		expCnt = 0;
		checkFrame();
	endtask

	// Still low after one cycle and high after two
	task automatic ackIrq();
		drive(1'b1, 1'b1, `BASE_INTACK, 8'h00, 1'b0);
		idleThenSample(1);
		checkFrame();
		idleThenSample(1);
		expIrq = 1'b1;
		checkFrame();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testSelects();
		logic [15:0] bases [13];
		logic [15:0] a;
		logic w;
		bases = '{`BASE_SCR0, `BASE_SCR1, `BASE_SND, `BASE_OBJ, `BASE_SPGM, `BASE_WDOG,
			`BASE_INTACK, `BASE_BANK, `BASE_LTH0, `BASE_LTH1, `BASE_LTH2, 16'h9800, 16'hC000};
		// Zero data keeps every latch at its reset value
		for (int i = 0; i < 13; i++) begin
			selectCycle(1'b1, 1'b0, bases[i], 8'h00);
			selectCycle(1'b1, 1'b1, bases[i], 8'h00);
		end
		for (int i = 0; i < 32; i++) begin
			a = 16'($random(seed));
			w = 1'($random(seed));
			// Random writes stay below the latch and watchdog strobes
			if (w)
				a[15] = 1'b0;
			selectCycle(1'b1, w, a, 8'($random(seed)));
		end
		selectCycle(1'b0, 1'b0, `BASE_SCR0, 8'h00);
		selectCycle(1'b0, 1'b0, `BASE_MPGM, 8'h00);
	endtask

	task automatic testLatches();
		logic [7:0] d;
		int layer;
		for (int g = 0; g < 2; g++) begin
			for (int i = 0; i < 8; i++) begin
				d = 8'($random(seed));
				drive(1'b1, 1'b1, (g == 0 ? `BASE_LTH0 : `BASE_LTH1) + 16'(i), d, 1'b0);
				layer = 2 * g + i / 4;
				case (i % 4)
					0: expScroll[layer][15:8] = d;
					1: expScroll[layer][7:0] = d;
					2: expPrio[layer] = d[2:0];
					// Index 7 is a hole
					default: begin
						if (i == 3)
							expRom[g] = d;
					end
				endcase
				idleThenSample(2);
				checkLatches();
			end
		end
	endtask

	task automatic testOtherRegs();
		logic [7:0] d;
		d = 8'($random(seed)) | 8'h10;
		drive(1'b1, 1'b1, `BASE_LTH2, d, 1'b0);
		idleThenSample(2);
		expBack = d;
		checkLatches();
		// Only bit 0 reaches the tile bank
		drive(1'b1, 1'b1, `BASE_BANK, 8'hFE, 1'b0);
		idleThenSample(2);
		checkLatches();
		drive(1'b1, 1'b1, `BASE_BANK, 8'h01, 1'b0);
		idleThenSample(2);
		expTile = 1'b1;
		checkLatches();
		drive(1'b1, 1'b0, `BASE_LTH2, ~d, 1'b0);
		drive(1'b1, 1'b0, `BASE_BANK, 8'h00, 1'b0);
		idleThenSample(2);
		checkLatches();
	endtask

	// Counts 8 to 10 pull nRes low until the wrap releases it
	task automatic testWatchdogTimeout();
		repeat (12) tickFrame();
	endtask

	task automatic testWatchdogClear();
		clearWatchdog();
		for (int i = 1; i <= 10; i++) begin
			tickFrame();
			if (i % 4 == 0)
				clearWatchdog();
		end
		while (expCnt != 7)
			tickFrame();
		// Clear reaches the counter on the same edge as the tick
		drive(1'b1, 1'b1, `BASE_WDOG, 8'h00, 1'b0);
		drive(1'b0, 1'b0, 16'h0000, 8'h00, 1'b1);
		idleThenSample(1);
		expCnt = 0;
		expIrq = 1'b0;
		checkFrame();
		repeat (8) tickFrame();
		clearWatchdog();
	endtask

	task automatic testInterrupt();
		ackIrq();
		tickFrame();
		ackIrq();
		tickFrame();
		// Tick wins over an acknowledge landing on the same edge
		drive(1'b1, 1'b1, `BASE_INTACK, 8'h00, 1'b0);
		drive(1'b0, 1'b0, 16'h0000, 8'h00, 1'b1);
		idleThenSample(1);
		expCnt = expCnt + 1;
		checkFrame();
		idleThenSample(1);
		checkFrame();
		ackIrq();
	endtask

	initial begin
		seed = 34;
		busValid <= 1'b0;
		busWrite <= 1'b0;
		addr <= '0;
		data <= '0;
		frameTick <= 1'b0;
		for (int i = 0; i < 4; i++) begin
			expScroll[i] = '0;
			expPrio[i] = '0;
		end
		expRom[0] = '0;
		expRom[1] = '0;
		expBack = '0;
		expTile = 1'b0;
		expIrq = 1'b1;
		expCnt = 0;
		waitResetRelease();
		idleThenSample(1);
		selectCycle(1'b0, 1'b0, 16'h0000, 8'h00);
		checkLatches();
		checkFrame();
		testSelects();
		testLatches();
		testOtherRegs();
		testWatchdogTimeout();
		testWatchdogClear();
		testInterrupt();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic nVBLK,
	output logic rstN
);

	// 10 ns period, first rising edge at 5 ns
	initial begin
		nVBLK = 1'b0;
		forever #5 nVBLK = ~nVBLK;
	end

	// Reset low across the first four rising edges
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge nVBLK);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/subBusTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "subBusCfg.svh"

module subBusTop (
	input  wire logic                   nVBLK,
	input  wire logic                   rstN,
	input  wire logic                   busValid,
	input  wire logic                   busWrite,
	input  wire logic [`SUB_ADDR_W-1:0] addr,
	input  wire logic [`SUB_DATA_W-1:0] data,
	input  wire logic                   frameTick,
	output logic                        nScr0,
	output logic                        nScr1,
	output logic                        nObj,
	output logic                        nSnd,
	output logic                        nSpgm,
	output logic                        nMpgm,
	output logic                        nBufEn,
	output logic [`SCROLL_W-1:0]        scrollX0,
	output logic [`SCROLL_W-1:0]        scrollX1,
	output logic [`SCROLL_W-1:0]        scrollX2,
	output logic [`SCROLL_W-1:0]        scrollX3,
	output logic [`PRIO_W-1:0]          prio0,
	output logic [`PRIO_W-1:0]          prio1,
	output logic [`PRIO_W-1:0]          prio2,
	output logic [`PRIO_W-1:0]          prio3,
	output logic [`SUB_DATA_W-1:0]      romBank0,
	output logic [`SUB_DATA_W-1:0]      romBank1,
	output logic [`SUB_DATA_W-1:0]      backColor,
	output logic                        tileBank,
	output logic                        nRes,
	output logic                        nIrq
);

	// Registered bus cycle shared by latch and frame stages
	subBusPkg::region_e s1Region;
	logic s1Valid;
	logic s1Write;
	logic [`LATCH_IDX_W-1:0] s1Index;
	logic [`SUB_DATA_W-1:0] s1Data;

	////////////////////////////////////////////////////////////////////////////
	// Decode stage
	////////////////////////////////////////////////////////////////////////////

	// Chip selects leave the board straight from here
	addressDecoder addressDecoder_i (
		.nVBLK(nVBLK), .rstN(rstN),
		.busValid(busValid), .busWrite(busWrite), .addr(addr), .data(data),
		.s1Region(s1Region), .s1Valid(s1Valid), .s1Write(s1Write),
		.s1Index(s1Index), .s1Data(s1Data),
		.nScr0(nScr0), .nScr1(nScr1), .nObj(nObj), .nSnd(nSnd),
		.nSpgm(nSpgm), .nMpgm(nMpgm), .nBufEn(nBufEn)
	);

	////////////////////////////////////////////////////////////////////////////
	// Latch and frame stages
	////////////////////////////////////////////////////////////////////////////

	videoLatches videoLatches_i (
		.nVBLK(nVBLK), .rstN(rstN),
		.s1Valid(s1Valid), .s1Write(s1Write), .s1Region(s1Region),
		.s1Index(s1Index), .s1Data(s1Data),
		.scrollX0(scrollX0), .scrollX1(scrollX1), .scrollX2(scrollX2), .scrollX3(scrollX3),
		.prio0(prio0), .prio1(prio1), .prio2(prio2), .prio3(prio3),
		.romBank0(romBank0), .romBank1(romBank1),
		.backColor(backColor), .tileBank(tileBank)
	);

	// Frame tick enters here directly, one stage ahead of bus strobes
	frameWatchdog frameWatchdog_i (
		.nVBLK(nVBLK), .rstN(rstN), .frameTick(frameTick),
		.s1Valid(s1Valid), .s1Write(s1Write), .s1Region(s1Region),
		.nRes(nRes), .nIrq(nIrq)
	);

endmodule

`default_nettype wire

/* verilog/frameWatchdog.sv */
`timescale 1ns/1ps
`default_nettype none

`include "subBusCfg.svh"

module frameWatchdog (
	input  wire logic               nVBLK,
	input  wire logic               rstN,
	input  wire logic               frameTick,
	input  wire logic               s1Valid,
	input  wire logic               s1Write,
	input  wire subBusPkg::region_e s1Region,
	output logic                    nRes,
	output logic                    nIrq
);

	////////////////////////////////////////////////////////////////////////////
	// Bus strobes from the decode stage
	////////////////////////////////////////////////////////////////////////////

	logic [`WDOG_W-1:0] wdogCnt;
	logic wdogClear;
	logic intAck;
	logic atWrap;

	// Watchdog clear and interrupt acknowledge strobes
	assign wdogClear = s1Valid && s1Write && (s1Region == subBusPkg::regWdog);
	assign intAck = s1Valid && s1Write && (s1Region == subBusPkg::regIntAck);

	// Decade style counter tops out at the wrap count
	assign atWrap = (wdogCnt == `WDOG_W'(`WDOG_WRAP));

	////////////////////////////////////////////////////////////////////////////
	// Watchdog counter
	////////////////////////////////////////////////////////////////////////////

	// Clear beats a coincident frame tick
	always_ff @(posedge nVBLK) begin
		if (!rstN) begin
			wdogCnt <= '0;
		end else if (wdogClear) begin
			wdogCnt <= '0;
		end else if (frameTick) begin
			if (atWrap)
				wdogCnt <= '0;
			else
				wdogCnt <= wdogCnt + `WDOG_W'(1);
		end
	end

	// Board reset held low through the top counts
	assign nRes = (wdogCnt < `WDOG_W'(`WDOG_RESET_AT));

	////////////////////////////////////////////////////////////////////////////
	// Vertical blank interrupt
	////////////////////////////////////////////////////////////////////////////

	// A new blank wins over a late acknowledge
	always_ff @(posedge nVBLK) begin
		if (!rstN)
			nIrq <= 1'b1;
		else if (frameTick)
			nIrq <= 1'b0;
		else if (intAck)
			nIrq <= 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/videoLatches.sv */
`timescale 1ns/1ps
`default_nettype none

`include "subBusCfg.svh"

module videoLatches (
	input  wire logic                    nVBLK,
	input  wire logic                    rstN,
	input  wire logic                    s1Valid,
	input  wire logic                    s1Write,
	input  wire subBusPkg::region_e      s1Region,
	input  wire logic [`LATCH_IDX_W-1:0] s1Index,
	input  wire logic [`SUB_DATA_W-1:0]  s1Data,
	output logic [`SCROLL_W-1:0]         scrollX0,
	output logic [`SCROLL_W-1:0]         scrollX1,
	output logic [`SCROLL_W-1:0]         scrollX2,
	output logic [`SCROLL_W-1:0]         scrollX3,
	output logic [`PRIO_W-1:0]           prio0,
	output logic [`PRIO_W-1:0]           prio1,
	output logic [`PRIO_W-1:0]           prio2,
	output logic [`PRIO_W-1:0]           prio3,
	output logic [`SUB_DATA_W-1:0]       romBank0,
	output logic [`SUB_DATA_W-1:0]       romBank1,
	output logic [`SUB_DATA_W-1:0]       backColor,
	output logic                         tileBank
);

	////////////////////////////////////////////////////////////////////////////
	// Write decode
	////////////////////////////////////////////////////////////////////////////

	logic [`SCROLL_W-1:0] scrollQ [4];
	logic [`PRIO_W-1:0] prioQ [4];
	logic [`SUB_DATA_W-1:0] romBankQ [2];
	logic wrGroup;
	logic wrBack;
	logic wrBank;
	logic groupSel;
	logic [1:0] layer;
	logic [1:0] field;

	// Valid write into one of the two scroll groups
	assign wrGroup = s1Valid && s1Write &&
		((s1Region == subBusPkg::regLth0) || (s1Region == subBusPkg::regLth1));
	assign wrBack = s1Valid && s1Write && (s1Region == subBusPkg::regLth2);
	assign wrBank = s1Valid && s1Write && (s1Region == subBusPkg::regBank);

	// Group 0 holds layers 0 and 1 and group 1 holds layers 2 and 3
	assign groupSel = (s1Region == subBusPkg::regLth1);

	// Index bit 2 picks the second layer of the group
	assign layer = {groupSel, s1Index[2]};
	assign field = s1Index[1:0];

	////////////////////////////////////////////////////////////////////////////
	// Latch registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge nVBLK) begin
		if (!rstN) begin
			for (int i = 0; i < 4; i++) begin
				scrollQ[i] <= '0;
				prioQ[i] <= '0;
			end
			romBankQ[0] <= '0;
			romBankQ[1] <= '0;
			backColor <= '0;
			tileBank <= 1'b0;
		end else begin
			if (wrGroup) begin
				case (field)
					// Scroll high then low byte
					2'd0: scrollQ[layer][`SCROLL_W-1:`SUB_DATA_W] <= s1Data;
					2'd1: scrollQ[layer][`SUB_DATA_W-1:0] <= s1Data;
					2'd2: prioQ[layer] <= s1Data[`PRIO_W-1:0];
					// Index 3 is the group ROM bank and index 7 is unused
					default: begin
						if (!s1Index[2])
							romBankQ[groupSel] <= s1Data;
					end
				endcase
			end
			if (wrBack)
				backColor <= s1Data;
			// Only data bit 0 is wired to the bank flop
			if (wrBank)
				tileBank <= s1Data[0];
		end
	end

	// Fan out to named layer outputs
	assign scrollX0 = scrollQ[0];
	assign scrollX1 = scrollQ[1];
	assign scrollX2 = scrollQ[2];
	assign scrollX3 = scrollQ[3];
	assign prio0 = prioQ[0];
	assign prio1 = prioQ[1];
	assign prio2 = prioQ[2];
	assign prio3 = prioQ[3];
	assign romBank0 = romBankQ[0];
	assign romBank1 = romBankQ[1];

endmodule

`default_nettype wire

/* verilog/addressDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "subBusCfg.svh"

module addressDecoder (
	input  wire logic                    nVBLK,
	input  wire logic                    rstN,
	input  wire logic                    busValid,
	input  wire logic                    busWrite,
	input  wire logic [`SUB_ADDR_W-1:0]  addr,
	input  wire logic [`SUB_DATA_W-1:0]  data,
	output subBusPkg::region_e           s1Region,
	output logic                         s1Valid,
	output logic                         s1Write,
	output logic [`LATCH_IDX_W-1:0]      s1Index,
	output logic [`SUB_DATA_W-1:0]       s1Data,
	output logic                         nScr0,
	output logic                         nScr1,
	output logic                         nObj,
	output logic                         nSnd,
	output logic                         nSpgm,
	output logic                         nMpgm,
	output logic                         nBufEn
);

	////////////////////////////////////////////////////////////////////////////
	// Region classification
	////////////////////////////////////////////////////////////////////////////

	// Half open range check on the full address
	function automatic logic inRange(input logic [`SUB_ADDR_W-1:0] a,
			input logic [`SUB_ADDR_W-1:0] lo, input logic [`SUB_ADDR_W-1:0] hi);
		return (a >= lo) && (a < hi);
	endfunction

	// First match wins, so sound beats object RAM
	function automatic subBusPkg::region_e decodeRegion(input logic [`SUB_ADDR_W-1:0] a,
			input logic wr);
		subBusPkg::region_e r;
		r = subBusPkg::regNone;
		if (inRange(a, `BASE_SCR0, `BASE_SCR1))
			r = subBusPkg::regScr0;
		else if (inRange(a, `BASE_SCR1, `BASE_SND))
			r = subBusPkg::regScr1;
		else if (inRange(a, `BASE_SND, `BASE_OBJ))
			r = subBusPkg::regSnd;
		else if (inRange(a, `BASE_OBJ, `BASE_SPGM))
			r = subBusPkg::regObj;
		else if (inRange(a, `BASE_SPGM, `BASE_WDOG))
			r = subBusPkg::regSpgm;
		// Write only strobes fall through to regNone on reads
		else if (wr && inRange(a, `BASE_WDOG, `BASE_INTACK))
			r = subBusPkg::regWdog;
		else if (wr && inRange(a, `BASE_INTACK, `BASE_BANK))
			r = subBusPkg::regIntAck;
		else if (wr && inRange(a, `BASE_BANK, `BASE_LTH0))
			r = subBusPkg::regBank;
		else if (inRange(a, `BASE_LTH0, `BASE_LTH1))
			r = subBusPkg::regLth0;
		else if (inRange(a, `BASE_LTH1, `BASE_LTH1_END))
			r = subBusPkg::regLth1;
		else if (inRange(a, `BASE_LTH2, `BASE_LTH2_END))
			r = subBusPkg::regLth2;
		return r;
	endfunction

	subBusPkg::region_e region;
	logic selScr0;
	logic selScr1;
	logic selObj;
	logic selSnd;
	logic selSpgm;
	logic selMpgm;
	logic selBuf;

	assign region = decodeRegion(addr, busWrite);

	// Video and sound selects for either direction
	assign selScr0 = (region == subBusPkg::regScr0);
	assign selScr1 = (region == subBusPkg::regScr1);
	assign selObj = (region == subBusPkg::regObj);
	assign selSnd = (region == subBusPkg::regSnd);

	// Program ROMs are read only
	assign selSpgm = !busWrite && (region == subBusPkg::regSpgm);
	assign selMpgm = !busWrite && (addr >= `BASE_MPGM);

	// Data buffer opens for any video, sound or scroll latch access
	assign selBuf = selScr0 || selScr1 || selObj || selSnd ||
		(region == subBusPkg::regLth0) || (region == subBusPkg::regLth1);

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 registers
	////////////////////////////////////////////////////////////////////////////

	// Control and selects, all selects idle high
	always_ff @(posedge nVBLK) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s1Region <= subBusPkg::regNone;
			nScr0 <= 1'b1;
			nScr1 <= 1'b1;
			nObj <= 1'b1;
			nSnd <= 1'b1;
			nSpgm <= 1'b1;
			nMpgm <= 1'b1;
			nBufEn <= 1'b1;
		end else begin
			s1Valid <= busValid;
			s1Region <= region;
			nScr0 <= !(busValid && selScr0);
			nScr1 <= !(busValid && selScr1);
			nObj <= !(busValid && selObj);
			nSnd <= !(busValid && selSnd);
			nSpgm <= !(busValid && selSpgm);
			nMpgm <= !(busValid && selMpgm);
			nBufEn <= !(busValid && selBuf);
		end
	end

	// Cycle payload, qualified downstream by s1Valid
	always_ff @(posedge nVBLK) begin
		s1Write <= busWrite;
		s1Index <= addr[`LATCH_IDX_W-1:0];
		s1Data <= data;
	end

endmodule

`default_nettype wire

/* verilog/subBusPkg.sv */
`default_nettype none

package subBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// Decoded memory region of one bus cycle
	////////////////////////////////////////////////////////////////////////////

	// Listed in decode priority order
	typedef enum logic [3:0] {
		// Video RAM 1 at 0000h
		regScr0,
		// Video RAM 2 at 2000h
		regScr1,
		// Sound chip shared RAM at 4000h, ahead of object RAM
		regSnd,
		// Object RAM at 4400h
		regObj,
		// Sub program ROM at 6000h
		regSpgm,
		// Watchdog clear at 8000h, write only
		regWdog,
		// Interrupt acknowledge at 8400h, write only
		regIntAck,
		// Tile bank select at 8800h, write only
		regBank,
		// Scroll and priority for layers 0 and 1
		regLth0,
		// Scroll and priority for layers 2 and 3
		regLth1,
		// Back colour at A000h
		regLth2,
		// Unmapped or wrong direction
		regNone
	} region_e;

endpackage

`default_nettype wire

/* verilog/subBusCfg.svh */
`ifndef SUB_BUS_CFG_SVH
`define SUB_BUS_CFG_SVH

// Secondary CPU bus widths
`define SUB_ADDR_W 16
`define SUB_DATA_W 8

// Latch register widths
`define LATCH_IDX_W 3
`define SCROLL_W 16
`define PRIO_W 3

// Frame watchdog counts in vertical blanks
`define WDOG_W 4
`define WDOG_WRAP 10
`define WDOG_RESET_AT 8

// Region base addresses in priority order
`define BASE_SCR0 16'h0000
`define BASE_SCR1 16'h2000
`define BASE_SND 16'h4000
`define BASE_OBJ 16'h4400
`define BASE_SPGM 16'h6000
`define BASE_WDOG 16'h8000
`define BASE_INTACK 16'h8400
`define BASE_BANK 16'h8800
`define BASE_LTH0 16'h9000
`define BASE_LTH1 16'h9400
`define BASE_LTH1_END 16'h9800
`define BASE_LTH2 16'hA000
`define BASE_LTH2_END 16'hA400
`define BASE_MPGM 16'h8000

`endif
